//--- logic/regStatusFile.sv
`timescale 1ns/10ps

`include "rob_config.svh"

module regStatusFile
    import robPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  regIdx   readReg1,
    input  regIdx   readReg2,
    output logic    readBusy1,
    output logic    readBusy2,
    output robTag   readTag1,
    output robTag   readTag2,
    output dataWord readData1,
    output dataWord readData2,
    input  logic    renameValid,
    input  regIdx   renameReg,
    input  robTag   renameTag,
    input  logic    commitWrite,
    input  regIdx   commitReg,
    input  dataWord commitData,
    input  robTag   commitTag
);

    dataWord regValue [`regCount];
    robTag   busyTag [`regCount];
    logic [`regCount-1:0] regBusy;

    logic clearHit1;
    logic clearHit2;

    // commit of the latest producer frees the register this cycle
    assign clearHit1 = commitWrite && (commitReg == readReg1) && (commitTag == busyTag[readReg1]);
    assign clearHit2 = commitWrite && (commitReg == readReg2) && (commitTag == busyTag[readReg2]);

    assign readBusy1 = regBusy[readReg1] && !clearHit1;
    assign readBusy2 = regBusy[readReg2] && !clearHit2;
    assign readTag1 = busyTag[readReg1];
    assign readTag2 = busyTag[readReg2];
    assign readData1 = clearHit1 ? commitData : regValue[readReg1];
    assign readData2 = clearHit2 ? commitData : regValue[readReg2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `regCount; i++) begin
                regValue[i] <= '0;
                busyTag[i] <= '0;
            end
            regBusy <= '0;
        end else begin
            if (commitWrite) begin
                regValue[commitReg] <= commitData;
                // older commit leaves a newer rename busy
                if (busyTag[commitReg] == commitTag) begin
                    regBusy[commitReg] <= 1'b0;
                end
            end
            // placed last so a same-cycle rename overrides the clear
            if (renameValid) begin
                regBusy[renameReg] <= 1'b1;
                busyTag[renameReg] <= renameTag;
            end
        end
    end

endmodule

//--- logic/renameStage.sv
`timescale 1ns/10ps

module renameStage
    import robPkg::*;
(
    input  regIdx   issueSrc1,
    input  regIdx   issueSrc2,
    output regIdx   readReg1,
    output regIdx   readReg2,
    input  logic    readBusy1,
    input  logic    readBusy2,
    input  robTag   readTag1,
    input  robTag   readTag2,
    input  dataWord readData1,
    input  dataWord readData2,
    output robTag   lookupTag1,
    output robTag   lookupTag2,
    input  logic    lookupReady1,
    input  logic    lookupReady2,
    input  dataWord lookupData1,
    input  dataWord lookupData2,
    output logic    operand1Ready,
    output dataWord operand1Data,
    output robTag   operand1Tag,
    output logic    operand2Ready,
    output dataWord operand2Data,
    output robTag   operand2Tag
);

    assign readReg1 = issueSrc1;
    assign readReg2 = issueSrc2;

    // pending producer is looked up in the buffer
    assign lookupTag1 = readTag1;
    assign lookupTag2 = readTag2;

    always_comb begin
        if (!readBusy1) begin
            operand1Ready = 1'b1;
            operand1Data = readData1;
        end else begin
            operand1Ready = lookupReady1;
            operand1Data = lookupData1;
        end
        if (!readBusy2) begin
            operand2Ready = 1'b1;
            operand2Data = readData2;
        end else begin
            operand2Ready = lookupReady2;
            operand2Data = lookupData2;
        end
    end

    // tag the consumer waits on when not ready
    assign operand1Tag = readTag1;
    assign operand2Tag = readTag2;

endmodule

//--- logic/reorderBuffer.sv
`timescale 1ns/10ps

`include "rob_config.svh"

module reorderBuffer
    import robPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     issueValid,
    input  instClass issueClass,
    input  regIdx    issueDest,
    output robTag    issueTag,
    output logic     robFull,
    output logic     renameStrobe,
    output robTag    renameTag,
    input  logic     aluValid,
    input  robTag    aluTag,
    input  dataWord  aluData,
    input  logic     branchValid,
    input  robTag    branchTag,
    input  dataWord  branchData,
    input  logic     lsuValid,
    input  robTag    lsuTag,
    input  dataWord  lsuData,
    input  robTag    lookupTag1,
    input  robTag    lookupTag2,
    output logic     lookupReady1,
    output logic     lookupReady2,
    output dataWord  lookupData1,
    output dataWord  lookupData2,
    output logic     commitValid,
    output logic     commitWrite,
    output regIdx    commitReg,
    output dataWord  commitData,
    output robTag    commitTag
);

    instClass entryClass [`robEntries];
    regIdx    entryDest [`robEntries];
    dataWord  entryData [`robEntries];
    logic [`robEntries-1:0] entryDone;

    robTag headPtr;
    robTag tailPtr;
    // one bit wider than a tag so a full buffer is distinguishable
    logic [`robTagWidth:0] count;

    logic issueAccept;

    assign robFull = (count == (`robTagWidth+1)'(`robEntries));
    assign issueAccept = issueValid && !robFull;
    assign issueTag = tailPtr;

    // register file only tracks producers that write a register
    assign renameStrobe = issueAccept && (issueClass == classNormal);
    assign renameTag = tailPtr;

    // head retires in the cycle it is seen done
    assign commitValid = (count != '0) && entryDone[headPtr];
    assign commitWrite = commitValid && (entryClass[headPtr] == classNormal);
    assign commitReg = entryDest[headPtr];
    assign commitData = entryData[headPtr];
    assign commitTag = headPtr;

    // strobes this cycle win over the stored entry
    function automatic void findResult(input robTag tag, output logic ready,
                                       output dataWord data);
        if (aluValid && aluTag == tag) begin
            ready = 1'b1;
            data = aluData;
        end else if (branchValid && branchTag == tag) begin
            ready = 1'b1;
            data = branchData;
        end else if (lsuValid && lsuTag == tag) begin
            ready = 1'b1;
            data = lsuData;
        end else begin
            ready = entryDone[tag];
            data = entryData[tag];
        end
    endfunction

    always_comb begin
        findResult(lookupTag1, lookupReady1, lookupData1);
        findResult(lookupTag2, lookupReady2, lookupData2);
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (issueAccept) begin
            entryClass[tailPtr] <= issueClass;
            entryDest[tailPtr] <= issueDest;
        end
        if (aluValid) begin
            entryData[aluTag] <= aluData;
        end
        if (branchValid) begin
            entryData[branchTag] <= branchData;
        end
        if (lsuValid) begin
            entryData[lsuTag] <= lsuData;
        end
    end

    // strobes never target the tail being issued
    always_ff @(posedge clk) begin
        if (rst) begin
            entryDone <= '0;
        end else begin
            if (issueAccept) begin
                entryDone[tailPtr] <= 1'b0;
            end
            if (aluValid) begin
                entryDone[aluTag] <= 1'b1;
            end
            if (branchValid) begin
                entryDone[branchTag] <= 1'b1;
            end
            if (lsuValid) begin
                entryDone[lsuTag] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
        end else begin
            if (commitValid) begin
                headPtr <= headPtr + 1'b1;
            end
            if (issueAccept) begin
                tailPtr <= tailPtr + 1'b1;
            end
            case ({issueAccept, commitValid})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- logic/robPkg.sv
`include "rob_config.svh"

package robPkg;

    // names the buffer entry that produces a value
    typedef logic [`robTagWidth-1:0] robTag;

    // architectural register number
    typedef logic [`regIdxWidth-1:0] regIdx;

    // operand or result value
    typedef logic [`dataWidth-1:0] dataWord;

    // only normal entries write a register at retirement
    typedef enum logic [1:0] {
        classNormal = 2'd0,
        classBranch = 2'd1,
        classStore  = 2'd2
    } instClass;

endpackage

//--- logic/robSubsystem.sv
`timescale 1ns/10ps

module robSubsystem
    import robPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     issueValid,
    input  instClass issueClass,
    input  regIdx    issueDest,
    input  regIdx    issueSrc1,
    input  regIdx    issueSrc2,
    output robTag    issueTag,
    output logic     robFull,
    output logic     operand1Ready,
    output dataWord  operand1Data,
    output robTag    operand1Tag,
    output logic     operand2Ready,
    output dataWord  operand2Data,
    output robTag    operand2Tag,
    input  logic     aluValid,
    input  robTag    aluTag,
    input  dataWord  aluData,
    input  logic     branchValid,
    input  robTag    branchTag,
    input  dataWord  branchData,
    input  logic     lsuValid,
    input  robTag    lsuTag,
    input  dataWord  lsuData,
    output logic     commitValid,
    output logic     commitWrite,
    output regIdx    commitReg,
    output dataWord  commitData,
    output robTag    commitTag
);

    logic    renameStrobe;
    robTag   renameTag;
    regIdx   readReg1;
    regIdx   readReg2;
    logic    readBusy1;
    logic    readBusy2;
    robTag   readTag1;
    robTag   readTag2;
    dataWord readData1;
    dataWord readData2;
    robTag   lookupTag1;
    robTag   lookupTag2;
    logic    lookupReady1;
    logic    lookupReady2;
    dataWord lookupData1;
    dataWord lookupData2;

    reorderBuffer reorderBuffer_i (.*);

    // rename only on an accepted normal issue
    regStatusFile regStatusFile_i (
        .*,
        .renameValid(renameStrobe),
        .renameReg(issueDest)
    );

    renameStage renameStage_i (.*);

endmodule

//--- robSubsystem.f
+incdir+.
logic/robPkg.sv
logic/reorderBuffer.sv
logic/regStatusFile.sv
logic/renameStage.sv
logic/robSubsystem.sv
tests/robSubsystem_props.sv
tests/robSubsystemTb.sv

//--- rob_config.svh
`ifndef ROB_CONFIG_SVH
`define ROB_CONFIG_SVH

// buffer depth and index width
// depth must stay a power of two
`define robEntries 8
`define robTagWidth 3

// architectural register file
`define regCount 32
`define regIdxWidth 5

// operand and result width
`define dataWidth 32

`endif

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f robSubsystem.f --top-module robSubsystemTb -o simv

./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation passed" sim.log; then
    exit 0
fi
exit 1

//--- tests/robSubsystemTb.sv
`timescale 1ns/10ps

`include "rob_config.svh"

module robSubsystemTb
    import robPkg::*;
();

    logic     clk;
    logic     rst;
    logic     issueValid;
    instClass issueClass;
    regIdx    issueDest;
    regIdx    issueSrc1;
    regIdx    issueSrc2;
    robTag    issueTag;
    logic     robFull;
    logic     operand1Ready;
    dataWord  operand1Data;
    robTag    operand1Tag;
    logic     operand2Ready;
    dataWord  operand2Data;
    robTag    operand2Tag;
    logic     aluValid;
    robTag    aluTag;
    dataWord  aluData;
    logic     branchValid;
    robTag    branchTag;
    dataWord  branchData;
    logic     lsuValid;
    robTag    lsuTag;
    dataWord  lsuData;
    logic     commitValid;
    logic     commitWrite;
    regIdx    commitReg;
    dataWord  commitData;
    robTag    commitTag;

    // reference model
    dataWord  mReg [`regCount];
    logic     mBusy [`regCount];
    robTag    mBusyTag [`regCount];
    instClass mClass [`robEntries];
    regIdx    mDest [`robEntries];
    dataWord  mData [`robEntries];
    logic     mDone [`robEntries];
    robTag    pending [$];
    robTag    mTail;

    int errorCount = 0;
    int timeoutCount = 0;

    robSubsystem robSubsystem_i (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    task automatic clearInputs();
        issueValid = 1'b0;
        issueClass = classNormal;
        issueDest = '0;
        issueSrc1 = '0;
        issueSrc2 = '0;
        aluValid = 1'b0;
        aluTag = '0;
        aluData = '0;
        branchValid = 1'b0;
        branchTag = '0;
        branchData = '0;
        lsuValid = 1'b0;
        lsuTag = '0;
        lsuData = '0;
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            errorCount++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    // operand expectation straight from the lookup rules
    task automatic checkOperand(input int n, input regIdx src, input logic rdy,
                                input dataWord d, input robTag t);
        logic expReady;
        dataWord expData;
        robTag waitTag;
        waitTag = mBusyTag[src];
        expReady = 1'b1;
        expData = mReg[src];
        if (mBusy[src]) begin
            if (aluValid && aluTag == waitTag) begin
                expData = aluData;
            end else if (branchValid && branchTag == waitTag) begin
                expData = branchData;
            end else if (lsuValid && lsuTag == waitTag) begin
                expData = lsuData;
            end else begin
                expReady = mDone[waitTag];
                expData = mData[waitTag];
            end
        end
        checkValue($sformatf("operand%0dReady", n), 32'(rdy), 32'(expReady));
        if (expReady) begin
            checkValue($sformatf("operand%0dData", n), d, expData);
        end else begin
            checkValue($sformatf("operand%0dTag", n), 32'(t), 32'(waitTag));
        end
    endtask

    task automatic markDone(input robTag t, input dataWord d);
        mDone[t] = 1'b1;
        mData[t] = d;
    endtask

    // check the low phase, then advance the model at the edge
    task automatic stepCycle();
        logic expCommit;
        robTag h;
        #5;
        expCommit = (pending.size() > 0) && mDone[pending[0]];
        checkValue("robFull", 32'(robFull), 32'(pending.size() == `robEntries));
        checkValue("issueTag", 32'(issueTag), 32'(mTail));
        checkValue("commitValid", 32'(commitValid), 32'(expCommit));
        checkOperand(1, issueSrc1, operand1Ready, operand1Data, operand1Tag);
        checkOperand(2, issueSrc2, operand2Ready, operand2Data, operand2Tag);
        if (expCommit) begin
            h = pending[0];
            checkValue("commitTag", 32'(commitTag), 32'(h));
            checkValue("commitData", commitData, mData[h]);
            checkValue("commitWrite", 32'(commitWrite), 32'(mClass[h] == classNormal));
            if (mClass[h] == classNormal) begin
                checkValue("commitReg", 32'(commitReg), 32'(mDest[h]));
            end
        end else begin
            checkValue("commitWrite", 32'(commitWrite), 32'h0);
        end
        @(posedge clk);
        if (expCommit) begin
            h = pending.pop_front();
            if (mClass[h] == classNormal) begin
                mReg[mDest[h]] = mData[h];
                if (mBusyTag[mDest[h]] == h) begin
                    mBusy[mDest[h]] = 1'b0;
                end
            end
        end
        if (aluValid) begin
            markDone(aluTag, aluData);
        end
        if (branchValid) begin
            markDone(branchTag, branchData);
        end
        if (lsuValid) begin
            markDone(lsuTag, lsuData);
        end
        if (issueValid) begin
            mClass[mTail] = issueClass;
            mDest[mTail] = issueDest;
            mDone[mTail] = 1'b0;
            pending.push_back(mTail);
            if (issueClass == classNormal) begin
                mBusy[issueDest] = 1'b1;
                mBusyTag[issueDest] = mTail;
            end
            mTail = mTail + 1'b1;
        end
        @(negedge clk);
        clearInputs();
    endtask

    task automatic setIssue(input instClass c, input regIdx dest, input regIdx s1,
                            input regIdx s2);
        issueValid = 1'b1;
        issueClass = c;
        issueDest = dest;
        issueSrc1 = s1;
        issueSrc2 = s2;
    endtask

    task automatic driveResult(input int unit, input robTag t, input dataWord d);
        case (unit)
            0: begin
                aluValid = 1'b1;
                aluTag = t;
                aluData = d;
            end
            1: begin
                branchValid = 1'b1;
                branchTag = t;
                branchData = d;
            end
            default: begin
                lsuValid = 1'b1;
                lsuTag = t;
                lsuData = d;
            end
        endcase
    endtask

    // up to one result per unit, on random unfinished entries
    task automatic randomStrobes();
        int used;
        int base;
        used = 0;
        base = int'($urandom_range(0, 2));
        foreach (pending[i]) begin
            if (!mDone[pending[i]] && used < 3 && $urandom_range(0, 1) == 1) begin
                driveResult((base + used) % 3, pending[i], dataWord'($urandom()));
                used++;
            end
        end
    endtask

    task automatic randomIssue();
        setIssue(instClass'($urandom_range(0, 2)), regIdx'($urandom_range(0, 7)),
                 regIdx'($urandom_range(0, 7)), regIdx'($urandom_range(0, 7)));
    endtask

    task automatic drain();
        int guard;
        guard = 0;
        while (pending.size() > 0 && guard < 200) begin
            randomStrobes();
            stepCycle();
            guard++;
        end
        if (pending.size() > 0) begin
            timeoutCount++;
            $display("timeout while waiting for the buffer to drain");
        end
    endtask

    initial begin
        void'($urandom(32'h9ccc));
        clearInputs();
        rst = 1'b1;
        for (int i = 0; i < `regCount; i++) begin
            mReg[i] = '0;
            mBusy[i] = 1'b0;
            mBusyTag[i] = '0;
        end
        for (int i = 0; i < `robEntries; i++) begin
            mDone[i] = 1'b0;
            mData[i] = '0;
        end
        mTail = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // first step sees the reset state
        stepCycle();

        // producer, waiting consumer, then same-cycle bypass
        setIssue(classNormal, 5'd5, 5'd0, 5'd5);
        stepCycle();
        setIssue(classStore, 5'd1, 5'd5, 5'd3);
        stepCycle();
        setIssue(classNormal, 5'd7, 5'd5, 5'd5);
        driveResult(0, pending[0], 32'h0000_1234);
        stepCycle();
        // r5 renamed again while its old producer retires
        setIssue(classNormal, 5'd5, 5'd7, 5'd5);
        stepCycle();
        drain();
        setIssue(classBranch, 5'd2, 5'd5, 5'd7);
        stepCycle();
        drain();

        // fill the buffer without results
        while (pending.size() < `robEntries) begin
            randomIssue();
            stepCycle();
        end
        stepCycle();
        driveResult(1, pending[0], dataWord'($urandom()));
        stepCycle();
        stepCycle();
        drain();

        repeat (400) begin
            if (pending.size() < `robEntries && $urandom_range(0, 1) == 1) begin
                randomIssue();
            end
            randomStrobes();
            stepCycle();
        end
        drain();

        $display("errors: %0d  timeouts: %0d", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- tests/robSubsystem_props.sv
`timescale 1ns/10ps

module robSubsystem_props
    import robPkg::*;
(
    input logic  clk,
    input logic  rst,
    input logic  issueValid,
    input logic  robFull,
    input logic  commitValid,
    input logic  commitWrite,
    input robTag commitTag
);

    robTag lastTag;
    logic  seenCommit;

    always_ff @(posedge clk) begin
        if (rst) begin
            seenCommit <= 1'b0;
            lastTag <= '0;
        end else if (commitValid) begin
            seenCommit <= 1'b1;
            lastTag <= commitTag;
        end
    end

    noIssueWhenFull: assert property (@(posedge clk) disable iff (rst)
        issueValid |-> !robFull)
        else $error("issue strobed while the buffer is full");

    // retirement walks the buffer in order
    tagInOrder: assert property (@(posedge clk) disable iff (rst)
        (commitValid && seenCommit) |-> commitTag == robTag'(lastTag + 1'b1))
        else $error("commit tag skipped an entry");

    writeNeedsCommit: assert property (@(posedge clk) disable iff (rst)
        commitWrite |-> commitValid)
        else $error("register write without a commit");

    quietAfterReset: assert property (@(posedge clk)
        $fell(rst) |-> (!commitValid && !robFull))
        else $error("commit or full flag active right after reset");

endmodule

bind robSubsystem robSubsystem_props robSubsystem_props_i (.*);
